/* verilog/pi1_pkg.sv */
package pi1_pkg;

	// bus geometry
	localparam int ARCH_W = 32;
	localparam int SEL_W = ARCH_W / 8;
	localparam int ADDR_W = 30;

	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR = 2'b01,
		PI1_RD = 2'b10,
		// write new data, return the old word
		PI1_RDWR = 2'b11
	} pi1_op_t;

	// master to slave
	typedef struct packed {
		pi1_op_t op;
		logic [ADDR_W-1:0] addr;
		logic [ARCH_W-1:0] data;
		logic [SEL_W-1:0] sel;
	} pi1_req_t;

	// slave to master
	typedef struct packed {
		logic [ARCH_W-1:0] data;
		logic rdy;
	} pi1_rsp_t;

endpackage

/* verilog/soc_map_pkg.sv */
package soc_map_pkg;

	typedef logic [1:0] slot_t;

	// slave slots, the last one catches every unmapped address
	localparam slot_t SLOT_DEVTBL = 2'd0;
	localparam slot_t SLOT_RAM = 2'd1;
	localparam slot_t SLOT_INVALID = 2'd2;
	localparam int SLOT_COUNT = 3;

	// bases are word addresses, map sizes are in bytes
	localparam int unsigned DEVTBL_BASE = 'h000;
	localparam int unsigned DEVTBL_MAPSZ = 'h1000;
	localparam int unsigned RAM_BASE = 'h400;
	localparam int unsigned RAM_MAPSZ = 'h1000;
	localparam int unsigned INVALID_MAPSZ = 'h1000;

	// scratch ram holds 1024 words
	localparam int RAM_IDX_W = 10;

	// ids reported through the device table
	localparam logic [15:0] DEVID_DEVTBL = 16'd7;
	localparam logic [15:0] DEVID_RAM = 16'd1;
	localparam logic [15:0] DEVID_INVALID = 16'd0;

	// device table decodes 64 words, the last is the reset control register
	localparam int DEVTBL_IDX_W = 6;
	localparam int DEVTBL_CTRL_WORD = 63;

	// reset stretch counter width
	localparam int RST_CNTR_W = 4;

	// software reset request, bit 1 is rst1 and bit 0 is rst0
	typedef struct packed {
		logic rst1;
		logic rst0;
	} rst_req_t;

endpackage

/* verilog/pi1_router.sv */
`timescale 1ns/1ps

module pi1_router (
	input logic clk120mhz,
	input logic rst_p,
	input pi1_pkg::pi1_req_t req_i,
	output pi1_pkg::pi1_rsp_t rsp_o,
	output pi1_pkg::pi1_req_t devtbl_req_o,
	input pi1_pkg::pi1_rsp_t devtbl_rsp_i,
	output pi1_pkg::pi1_req_t ram_req_o,
	input pi1_pkg::pi1_rsp_t ram_rsp_i
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	slot_t dec_slot;
	slot_t sel_slot;
	logic ram_pend_q;

	// true when a word address falls inside a window given in bytes
	function automatic logic in_window(logic [ADDR_W-1:0] addr, int unsigned base,
			int unsigned mapsz);
		return (addr >= base) && (addr < base + mapsz / SEL_W);
	endfunction

	always_comb begin
		if (in_window(req_i.addr, DEVTBL_BASE, DEVTBL_MAPSZ)) begin
			dec_slot = SLOT_DEVTBL;
		end else if (in_window(req_i.addr, RAM_BASE, RAM_MAPSZ)) begin
			dec_slot = SLOT_RAM;
		end else begin
			dec_slot = SLOT_INVALID;
		end
	end

	// keep the ram selected until it has answered
	assign sel_slot = ram_pend_q ? SLOT_RAM : dec_slot;

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			ram_pend_q <= 1'b0;
		end else if (ram_rsp_i.rdy) begin
			ram_pend_q <= 1'b0;
		end else if (sel_slot == SLOT_RAM && req_i.op != PI1_NOP) begin
			ram_pend_q <= 1'b1;
		end
	end

	always_comb begin
		devtbl_req_o = req_i;
		ram_req_o = req_i;
		devtbl_req_o.op = PI1_NOP;
		ram_req_o.op = PI1_NOP;
		// slaves see offsets within their own window
		devtbl_req_o.addr = req_i.addr - ADDR_W'(DEVTBL_BASE);
		ram_req_o.addr = req_i.addr - ADDR_W'(RAM_BASE);
		case (sel_slot)
			SLOT_DEVTBL: begin
				devtbl_req_o.op = req_i.op;
				rsp_o = devtbl_rsp_i;
			end
			SLOT_RAM: begin
				ram_req_o.op = req_i.op;
				rsp_o = ram_rsp_i;
			end
			default: begin
				// invalid device, reads zero and drops writes
				rsp_o.data = '0;
				rsp_o.rdy = (req_i.op != PI1_NOP);
			end
		endcase
	end

endmodule

/* verilog/dev_table.sv */
`timescale 1ns/1ps

module dev_table (
	input logic clk120mhz,
	input logic rst_p,
	input pi1_pkg::pi1_req_t req_i,
	output pi1_pkg::pi1_rsp_t rsp_o,
	output soc_map_pkg::rst_req_t rst_req_o
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	logic [DEVTBL_IDX_W-1:0] word;
	logic [DEVTBL_IDX_W-2:0] entry;
	logic in_tbl;
	logic is_ctrl;
	logic [15:0] dev_id;
	logic [ARCH_W-1:0] mapsz;
	logic [ARCH_W-1:0] rd_data;
	rst_req_t ctrl_q;

	assign word = req_i.addr[DEVTBL_IDX_W-1:0];
	// two words per slot, id first then map size
	assign entry = word[DEVTBL_IDX_W-1:1];
	// offsets past the decoded 64 words read as zero
	assign in_tbl = (req_i.addr >> DEVTBL_IDX_W) == '0;
	assign is_ctrl = in_tbl && (word == DEVTBL_IDX_W'(DEVTBL_CTRL_WORD));

	always_comb begin
		dev_id = DEVID_INVALID;
		mapsz = INVALID_MAPSZ;
		case (entry)
			SLOT_DEVTBL: begin
				dev_id = DEVID_DEVTBL;
				mapsz = DEVTBL_MAPSZ;
			end
			SLOT_RAM: begin
				dev_id = DEVID_RAM;
				mapsz = RAM_MAPSZ;
			end
			default: begin
				dev_id = DEVID_INVALID;
				mapsz = INVALID_MAPSZ;
			end
		endcase
	end

	always_comb begin
		rd_data = '0;
		if (is_ctrl) begin
			rd_data = {{(ARCH_W - $bits(rst_req_t)){1'b0}}, ctrl_q};
		end else if (in_tbl && entry < SLOT_COUNT) begin
			rd_data = word[0] ? mapsz : {{(ARCH_W - 16){1'b0}}, dev_id};
		end
	end

	// table answers in the same cycle
	assign rsp_o.data = rd_data;
	assign rsp_o.rdy = (req_i.op != PI1_NOP);

	// cleared by core reset, so a warm request drops once the sequencer holds reset
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			ctrl_q <= '0;
		end else if ((req_i.op == PI1_WR || req_i.op == PI1_RDWR) && is_ctrl
				&& req_i.sel[0]) begin
			ctrl_q <= rst_req_t'(req_i.data[1:0]);
		end
	end

	assign rst_req_o = ctrl_q;

endmodule

/* verilog/scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram #(
	parameter int IDX_W = 10
) (
	input logic clk120mhz,
	input logic rst_p,
	input pi1_pkg::pi1_req_t req_i,
	output pi1_pkg::pi1_rsp_t rsp_o
);
	import pi1_pkg::*;

	logic [ARCH_W-1:0] mem [2**IDX_W];
	logic [ARCH_W-1:0] rd_q;
	logic rdy_q;
	logic accept;
	logic do_wr;
	logic do_rd;
	logic [IDX_W-1:0] idx;

	assign idx = req_i.addr[IDX_W-1:0];

	// while rdy is up the master still holds the answered request
	assign accept = (req_i.op != PI1_NOP) && !rdy_q;
	assign do_wr = accept && (req_i.op == PI1_WR || req_i.op == PI1_RDWR);
	assign do_rd = accept && (req_i.op == PI1_RD || req_i.op == PI1_RDWR);

	always_ff @(posedge clk120mhz) begin
		for (int b = 0; b < SEL_W; b++) begin
			if (do_wr && req_i.sel[b]) begin
				mem[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
			end
		end
		// old word is captured before the write lands, giving the rdwr swap
		if (do_rd) begin
			rd_q <= mem[idx];
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= accept;
		end
	end

	assign rsp_o.data = rd_q;
	assign rsp_o.rdy = rdy_q;

endmodule

/* verilog/rst_sequencer.sv */
`timescale 1ns/1ps

module rst_sequencer (
	input logic clk120mhz,
	input logic rst_p,
	input soc_map_pkg::rst_req_t rst_req_i,
	output logic core_rst_o
);
	import soc_map_pkg::*;

	logic warm_req;
	logic pwroff_req;
	logic [RST_CNTR_W-1:0] rst_cntr;
	logic pwroff_q;

	// cold reset has no separate path here and acts as warm
	assign warm_req = rst_req_i.rst1;
	assign pwroff_req = rst_req_i.rst0 && !rst_req_i.rst1;

	// reload while any reset source is active, then count down
	always_ff @(posedge clk120mhz) begin
		if (rst_p || warm_req) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// power-off holds the core until an external reset
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (pwroff_req) begin
			pwroff_q <= 1'b1;
		end
	end

	assign core_rst_o = (rst_cntr != '0) || pwroff_q;

endmodule

/* verilog/soc_fabric_top.sv */
`timescale 1ns/1ps

module soc_fabric_top (
	input logic clk120mhz,
	input logic rst_p,
	input pi1_pkg::pi1_req_t pi1_req_i,
	output pi1_pkg::pi1_rsp_t pi1_rsp_o,
	output logic core_rst_o
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	pi1_req_t devtbl_req;
	pi1_rsp_t devtbl_rsp;
	pi1_req_t ram_req;
	pi1_rsp_t ram_rsp;
	rst_req_t rst_req;

	rst_sequencer u_rst_seq (
		.clk120mhz (clk120mhz),
		.rst_p (rst_p),
		.rst_req_i (rst_req),
		.core_rst_o (core_rst_o)
	);

	// everything behind the sequencer runs on core reset
	pi1_router u_router (
		.clk120mhz (clk120mhz),
		.rst_p (core_rst_o),
		.req_i (pi1_req_i),
		.rsp_o (pi1_rsp_o),
		.devtbl_req_o (devtbl_req),
		.devtbl_rsp_i (devtbl_rsp),
		.ram_req_o (ram_req),
		.ram_rsp_i (ram_rsp)
	);

	dev_table u_devtbl (
		.clk120mhz (clk120mhz),
		.rst_p (core_rst_o),
		.req_i (devtbl_req),
		.rsp_o (devtbl_rsp),
		.rst_req_o (rst_req)
	);

	scratch_ram #(
		.IDX_W (RAM_IDX_W)
	) u_ram (
		.clk120mhz (clk120mhz),
		.rst_p (core_rst_o),
		.req_i (ram_req),
		.rsp_o (ram_rsp)
	);

endmodule

/* sim/soc_fabric_tb.sv */
`timescale 1ns/1ps

module soc_fabric_tb;
	import pi1_pkg::*;
	import soc_map_pkg::*;

	logic clk120mhz;
	logic rst_p;
	pi1_req_t pi1_req;
	pi1_rsp_t pi1_rsp;
	logic core_rst;

	logic [31:0] lcg_state;
	logic [31:0] ram_model [1024];
	int written[$];
	int checks;
	int errors;

	soc_fabric_top DUT (
		.clk120mhz (clk120mhz),
		.rst_p (rst_p),
		.pi1_req_i (pi1_req),
		.pi1_rsp_o (pi1_rsp),
		.core_rst_o (core_rst)
	);

	initial begin
		clk120mhz = 1'b0;
		forever #50 clk120mhz = ~clk120mhz;
	end

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// byte lanes with sel set take the new data
	function automatic logic [31:0] apply_sel(logic [31:0] old_w, logic [31:0] new_w,
			logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return res;
	endfunction

	task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task stop_on_timeout(input string what);
		$display("ERROR: %s", what);
		$display("checks %0d, value errors %0d, timeouts 1", checks, errors);
		$display("Test FAILED");
		$finish;
	endtask

	// request is held from 5 ns after an edge until the edge that sees rdy
	task bus_xfer(input pi1_op_t op, input int unsigned addr, input logic [31:0] wdata,
			input logic [3:0] sel, output logic [31:0] rdata);
		int cnt;
		logic done;
		pi1_req.op = op;
		pi1_req.addr = ADDR_W'(addr);
		pi1_req.data = wdata;
		pi1_req.sel = sel;
		rdata = '0;
		done = 1'b0;
		cnt = 0;
		while (!done && cnt < 50) begin
			#1;
			if (pi1_rsp.rdy) begin
				rdata = pi1_rsp.data;
				done = 1'b1;
			end
			@(posedge clk120mhz);
			#5;
			cnt++;
		end
		pi1_req.op = PI1_NOP;
		if (!done) begin
			stop_on_timeout($sformatf("no rdy within 50 cycles at word address %h", addr));
		end
	endtask

	task bus_read(input int unsigned addr, output logic [31:0] rdata);
		bus_xfer(PI1_RD, addr, 32'h0, 4'h0, rdata);
	endtask

	task bus_write(input int unsigned addr, input logic [31:0] wdata, input logic [3:0] sel);
		logic [31:0] unused;
		bus_xfer(PI1_WR, addr, wdata, sel, unused);
	endtask

	task hold_reset();
		rst_p = 1'b1;
		repeat (8) @(posedge clk120mhz);
		#5;
		check_value("core reset during rst_p", 32'd1, core_rst);
		rst_p = 1'b0;
	endtask

	task wait_reset_rise(input string name);
		int cnt;
		cnt = 0;
		while (!core_rst && cnt < 10) begin
			@(posedge clk120mhz);
			#5;
			cnt++;
		end
		if (!core_rst) begin
			stop_on_timeout({name, ": core reset did not rise within 10 cycles"});
		end
	endtask

	task wait_reset_release(input string name, input int min_cycles, input int max_cycles);
		int cnt;
		cnt = 0;
		while (core_rst && cnt < max_cycles) begin
			@(posedge clk120mhz);
			#5;
			cnt++;
		end
		if (core_rst) begin
			stop_on_timeout($sformatf("%s: core reset still high after %0d cycles", name,
				max_cycles));
		end else begin
			checks++;
			assert (cnt >= min_cycles) else begin
				errors++;
				$display("FAIL %s: expected at least %0d cycles, actual %0d", name,
					min_cycles, cnt);
			end
		end
	endtask

	task check_ram_model(input string name);
		logic [31:0] rd;
		foreach (written[i]) begin
			bus_read(RAM_BASE + written[i], rd);
			check_value(name, ram_model[written[i]], rd);
		end
	endtask

	task check_devtbl(input string name);
		logic [31:0] rd;
		logic [15:0] ids [SLOT_COUNT];
		int unsigned sizes [SLOT_COUNT];
		ids = '{DEVID_DEVTBL, DEVID_RAM, DEVID_INVALID};
		sizes = '{DEVTBL_MAPSZ, RAM_MAPSZ, INVALID_MAPSZ};
		for (int k = 0; k < SLOT_COUNT; k++) begin
			bus_read(DEVTBL_BASE + 2 * k, rd);
			check_value($sformatf("%s id slot %0d", name, k), {16'h0, ids[k]}, rd);
			bus_read(DEVTBL_BASE + 2 * k + 1, rd);
			check_value($sformatf("%s size slot %0d", name, k), sizes[k], rd);
		end
		for (int w = 2 * SLOT_COUNT; w < DEVTBL_CTRL_WORD; w++) begin
			bus_read(DEVTBL_BASE + w, rd);
			check_value($sformatf("%s word %0d", name, w), 32'h0, rd);
		end
		bus_read(DEVTBL_BASE + DEVTBL_CTRL_WORD, rd);
		check_value({name, " control word"}, 32'h0, rd);
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] wdata;
		logic [31:0] rnd;
		logic [3:0] sel;
		int idx;
		int unsigned bad_addr;
		lcg_state = 32'hbe1788ec;
		rst_p = 1'b1;
		pi1_req = '0;
		checks = 0;
		errors = 0;

		hold_reset();
		wait_reset_release("reset release", 15, 20);
		check_devtbl("device table");

		// every word starts from a full write so the model never holds unknown bytes
		repeat (32) begin
			idx = int'(next_rand() & 32'h3ff);
			wdata = next_rand();
			bus_write(RAM_BASE + idx, wdata, 4'hf);
			ram_model[idx] = wdata;
			wdata = next_rand();
			rnd = next_rand();
			sel = rnd[31:28];
			bus_write(RAM_BASE + idx, wdata, sel);
			ram_model[idx] = apply_sel(ram_model[idx], wdata, sel);
			written.push_back(idx);
		end
		check_ram_model("ram readback");

		// swap returns the old word and merges the new bytes
		idx = written[0];
		wdata = next_rand();
		rnd = next_rand();
		sel = rnd[31:28] | 4'h1;
		bus_xfer(PI1_RDWR, RAM_BASE + idx, wdata, sel, rd);
		check_value("rdwr old word", ram_model[idx], rd);
		ram_model[idx] = apply_sel(ram_model[idx], wdata, sel);
		bus_read(RAM_BASE + idx, rd);
		check_value("rdwr new word", ram_model[idx], rd);

		// above the ram window, low bits alias a written ram word
		idx = written[1];
		bad_addr = RAM_BASE + RAM_MAPSZ / 4 + idx;
		bus_read(bad_addr, rd);
		check_value("invalid read", 32'h0, rd);
		// low bits also alias the control word, rst0 there would power the core off
		bus_write(bad_addr | 32'h3f, 32'h1, 4'h1);
		bus_write(bad_addr, ~ram_model[idx], 4'hf);
		check_value("core reset after invalid write", 32'd0, core_rst);
		check_ram_model("ram after invalid write");
		check_devtbl("device table after invalid write");

		// warm reset through rst1
		bus_write(DEVTBL_BASE + DEVTBL_CTRL_WORD, 32'd2, 4'h1);
		wait_reset_rise("warm reset");
		wait_reset_release("warm reset release", 15, 20);
		bus_read(DEVTBL_BASE + DEVTBL_CTRL_WORD, rd);
		check_value("control word after warm reset", 32'h0, rd);
		check_ram_model("ram after warm reset");

		// power-off through rst0, only rst_p brings the core back
		bus_write(DEVTBL_BASE + DEVTBL_CTRL_WORD, 32'd1, 4'h1);
		wait_reset_rise("power-off");
		repeat (40) begin
			@(posedge clk120mhz);
			#5;
			check_value("power-off hold", 32'd1, core_rst);
		end
		hold_reset();
		wait_reset_release("release after power-off", 15, 20);

		$display("checks %0d, value errors %0d, timeouts 0", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* soc_fabric.f */
verilog/pi1_pkg.sv
verilog/soc_map_pkg.sv
verilog/pi1_router.sv
verilog/dev_table.sv
verilog/scratch_ram.sv
verilog/rst_sequencer.sv
verilog/soc_fabric_top.sv
sim/soc_fabric_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module soc_fabric_tb -f soc_fabric.f

out=$(./obj_dir/Vsoc_fabric_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Test OK"; then
	exit 0
else
	exit 1
fi
